/* run.sh */
#!/bin/sh
# Build and run the dino_game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module dino_game_tb \
	--Mdir obj_dir -o dino_game_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dino_game_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0

/* sim/dino_game_tb.sv */
`timescale 1ns/100ps

module dino_game_tb;
	import dino_pkg::*;

	localparam int TICK_CYCLES = 64;
	localparam int BAUD_DIV = 2;
	localparam int BIT_CYCLES = 16 * BAUD_DIV;
	localparam int RUN_PERIODS = 2000;
	localparam int TIMEOUT_CYCLES = (RUN_PERIODS + 50) * TICK_CYCLES;

	logic clock;
	logic rst_n;
	logic uart_rx;
	logic jump_key;
	logic duck_key;
	logic game_over;
	ypos_t dino_y;
	xpos_t obstacle_x;
	seg_t hex [6];

	// Stimulus state
	logic [31:0] seed = 32'h6c9d3faa;
	logic [9:0] frame;
	int uart_cyc = -1;
	bit uart_req = 0;
	int total_cycles = 0;

	// Reference model of the game stepped once per tick
	int m_y;
	int m_v;
	bit m_air;
	int m_duck;
	int m_x;
	logic [15:0] m_lfsr;
	int m_score;
	int m_high = 0;
	bit m_go;
	int pend;   // Pulse waiting for the next tick (0 none, 1 jump, 2 duck)

	tb_clock clock_i (.o_clock(clock));

	dino_game #(
		.TICK_CYCLES(TICK_CYCLES),
		.BAUD_DIV(BAUD_DIV)
	) dino_game_i (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_uart_rx(uart_rx),
		.i_jump_key(jump_key),
		.i_duck_key(duck_key),
		.o_game_over(game_over),
		.o_dino_y(dino_y),
		.o_obstacle_x(obstacle_x),
		.o_hex0(hex[0]),
		.o_hex1(hex[1]),
		.o_hex2(hex[2]),
		.o_hex3(hex[3]),
		.o_hex4(hex[4]),
		.o_hex5(hex[5])
	);

	always @(posedge clock) begin
		total_cycles <= total_cycles + 1;
		if (total_cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "Simulation stopped by timeout");
		end
	end

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		galois_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			seed = galois_step(seed);
			value = (value << 1) | int'(seed[0]);
		end
	endtask

	function automatic seg_t seven_seg(input int digit);
		case (digit)
			0: seven_seg = 7'b1000000;
			1: seven_seg = 7'b1111001;
			2: seven_seg = 7'b0100100;
			3: seven_seg = 7'b0110000;
			4: seven_seg = 7'b0011001;
			5: seven_seg = 7'b0010010;
			6: seven_seg = 7'b0000010;
			7: seven_seg = 7'b1111000;
			8: seven_seg = 7'b0000000;
			default: seven_seg = 7'b0010000;
		endcase
	endfunction

	// Inclusive box overlap of the dino hitbox and the obstacle
	function automatic bit boxes_hit(input int y, input bit ducked, input int x);
		int top;
		int bot;
		int left;
		top = y + (ducked ? int'(DUCK_TOP) : int'(STAND_TOP));
		bot = top + (ducked ? int'(DUCK_H) : int'(STAND_H));
		left = int'(DINO_X) + int'(DINO_HB_X_OFS);
		boxes_hit = (left + int'(DINO_HB_W) >= x) && (left <= x + OBS_SIZE) &&
			(bot >= int'(OBS_Y)) && (top <= int'(OBS_Y) + OBS_SIZE);
	endfunction

	task automatic reset_field;
		m_y = int'(GROUND_Y);
		m_v = 0;
		m_air = 0;
		m_duck = 0;
		m_x = int'(OBS_WRAP_X);
		m_lfsr = LFSR_SEED;
	endtask

	task automatic model_tick;
		int prev_x;
		int ny;
		if (m_go) begin
			pend = 0;
			return;
		end
		if (pend != 0 && !m_air && m_duck == 0) begin
			if (pend == 1) begin
				m_v = int'(JUMP_FORCE);
				m_air = 1;
			end else begin
				m_duck = DUCK_TICKS;
			end
		end
		pend = 0;
		prev_x = m_x;
		if (m_air) begin
			ny = m_y + m_v;
			if (ny >= int'(GROUND_Y)) begin
				m_y = int'(GROUND_Y);
				m_v = 0;
				m_air = 0;
			end else begin
				m_y = ny;
				m_v = m_v + int'(GRAVITY);
			end
		end
		if (m_duck > 0)
			m_duck--;
		m_x = (m_x <= 1) ? int'(OBS_WRAP_X) : m_x - 1;
		if (boxes_hit(m_y, m_duck > 0, m_x)) begin
			if (m_score > m_high)
				m_high = m_score;
			m_go = 1;
			reset_field();
		end else if (prev_x > int'(DINO_X) && m_x <= int'(DINO_X)) begin
			m_score++;
			m_x = int'(OBS_WRAP_X) + int'(m_lfsr[8:0]) % RESPAWN_SPAN;   // LFSR before its step
			m_lfsr = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[14] ^ m_lfsr[12] ^ m_lfsr[3]};
		end
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_outputs;
		compare("o_game_over", 32'(game_over), 32'(m_go));
		compare("o_dino_y", 32'(dino_y), 32'(m_y));
		compare("o_obstacle_x", 32'(obstacle_x), 32'(m_x));
		compare("o_hex0", 32'(hex[0]), 32'(seven_seg(m_score % 10)));
		compare("o_hex1", 32'(hex[1]), 32'(seven_seg((m_score / 10) % 10)));
		compare("o_hex2", 32'(hex[2]), 32'(seven_seg((m_score / 100) % 10)));
		compare("o_hex3", 32'(hex[3]), 32'(seven_seg(m_high % 10)));
		compare("o_hex4", 32'(hex[4]), 32'(seven_seg((m_high / 10) % 10)));
		compare("o_hex5", 32'(hex[5]), 32'(seven_seg((m_high / 100) % 10)));
	endtask

	// One tick period with the tick acting on phase 64
	task automatic run_period(input int key);
		for (int p = 1; p <= TICK_CYCLES; p++) begin
			@(posedge clock);
			if (p == 8) begin
				jump_key <= (key == 1);
				duck_key <= (key == 2);
			end else if (p == 9) begin
				jump_key <= 1'b0;
				duck_key <= 1'b0;
			end
			if (uart_req && p == 24) begin
				uart_cyc = 0;
				uart_req = 0;
			end
			if (uart_cyc >= 0) begin
				if (uart_cyc < 10 * BIT_CYCLES) begin
					uart_rx <= frame[uart_cyc / BIT_CYCLES];
					uart_cyc++;
				end else begin
					uart_rx <= 1'b1;
					uart_cyc = -1;
				end
			end
			if (p == TICK_CYCLES)
				model_tick();
			if (p == 32) begin
				@(negedge clock);
				check_outputs();
			end
		end
	endtask

	task automatic apply_reset;
		rst_n <= 1'b0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;   // Tick counter starts from this edge
		reset_field();
		m_score = 0;
		m_go = 0;
		pend = 0;
	endtask

	initial begin
		int action;
		int value;
		int periods;
		rst_n = 1'b0;
		uart_rx = 1'b1;
		jump_key = 1'b0;
		duck_key = 1'b0;
		periods = 0;
		apply_reset();
		while (periods < RUN_PERIODS) begin
			take_bits(3, action);
			if (action == 2 || action == 3) begin
				pend = action - 1;
				run_period(action - 1);
				periods++;
			end else if (action >= 4 && action <= 6) begin
				if (action == 4) begin
					value = int'(CMD_JUMP);
				end else if (action == 5) begin
					value = int'(CMD_DUCK);
				end else begin
					take_bits(8, value);
					if (value == int'(CMD_JUMP) || value == int'(CMD_DUCK))
						value = value ^ 1;
				end
				frame = {1'b1, 8'(value), 1'b0};
				uart_req = 1;
				repeat (5) run_period(0);
				// Stop bit lands in the sixth period
				if (value == int'(CMD_JUMP))
					pend = 1;
				else if (value == int'(CMD_DUCK))
					pend = 2;
				run_period(0);
				periods += 6;
			end else begin
				run_period(0);
				periods++;
			end
			if (m_go) begin
				run_period(0);   // Frozen field stays at its start values
				periods++;
				apply_reset();
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
	parameter real HALF_PERIOD = 2.0
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever #(HALF_PERIOD) o_clock = ~o_clock;
	end

endmodule

/* source/dino_game.sv */
`timescale 1ns/100ps

module dino_game #(
	parameter int TICK_CYCLES = 524288,   // Clocks per game tick
	parameter int BAUD_DIV = 27           // Clocks per 16x UART sample
) (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_uart_rx,
	input logic i_jump_key,
	input logic i_duck_key,
	output logic o_game_over,
	output dino_pkg::ypos_t o_dino_y,
	output dino_pkg::xpos_t o_obstacle_x,
	output dino_pkg::seg_t o_hex0,
	output dino_pkg::seg_t o_hex1,
	output dino_pkg::seg_t o_hex2,
	output dino_pkg::seg_t o_hex3,
	output dino_pkg::seg_t o_hex4,
	output dino_pkg::seg_t o_hex5
);
	import dino_pkg::*;

	logic byte_valid;
	logic [7:0] rx_byte;
	logic jump;
	logic duck;
	score_t score;
	score_t high_score;

	play_state_if play_state_i ();

	uart_rx #(
		.BAUD_DIV(BAUD_DIV)
	) uart_rx_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_rx(i_uart_rx),
		.o_byte_valid(byte_valid),
		.o_byte(rx_byte)
	);

	player_controls player_controls_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_jump_key(i_jump_key),
		.i_duck_key(i_duck_key),
		.i_byte_valid(byte_valid),
		.i_byte(rx_byte),
		.o_jump(jump),
		.o_duck(duck)
	);

	playfield #(
		.TICK_CYCLES(TICK_CYCLES)
	) playfield_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_jump(jump),
		.i_duck(duck),
		.state(play_state_i)
	);

	referee referee_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.state(play_state_i),
		.o_score(score),
		.o_high_score(high_score)
	);

	score_display score_display_i (
		.i_score(score),
		.i_high_score(high_score),
		.o_hex0(o_hex0),
		.o_hex1(o_hex1),
		.o_hex2(o_hex2),
		.o_hex3(o_hex3),
		.o_hex4(o_hex4),
		.o_hex5(o_hex5)
	);

	assign o_game_over = play_state_i.game_over;
	assign o_dino_y = play_state_i.dino_y;
	assign o_obstacle_x = play_state_i.obstacle_x;

endmodule

/* source/dino_pkg.sv */
package dino_pkg;

	typedef logic [8:0] xpos_t;          // Horizontal pixel position
	typedef logic [7:0] ypos_t;          // Vertical pixel position, grows downwards
	typedef logic signed [9:0] vel_t;    // Vertical speed in pixels per tick
	typedef logic [15:0] score_t;
	typedef logic [6:0] seg_t;           // Active low, segment a in bit 0

	typedef enum logic {
		RUNNING,
		AIRBORNE
	} jump_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Field and physics
	localparam int SCREEN_W = 320;
	localparam xpos_t DINO_X = 9'd52;
	localparam ypos_t GROUND_Y = 8'd109;
	localparam vel_t JUMP_FORCE = -10'sd10;
	localparam vel_t GRAVITY = 10'sd1;
	localparam int DUCK_TICKS = 24;
	localparam int DUCK_CNT_W = $clog2(DUCK_TICKS + 1);

	// Obstacle and respawn
	localparam ypos_t OBS_Y = 8'd102;
	localparam int OBS_SIZE = 16;
	localparam xpos_t OBS_WRAP_X = xpos_t'(SCREEN_W - OBS_SIZE);
	localparam int RESPAWN_SPAN = 100;
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	// Dino hitbox inside its 32x32 sprite box
	localparam xpos_t DINO_HB_X_OFS = 9'd6;
	localparam xpos_t DINO_HB_W = 9'd20;
	localparam ypos_t STAND_TOP = 8'd2;
	localparam ypos_t STAND_H = 8'd28;
	localparam ypos_t DUCK_TOP = 8'd16;
	localparam ypos_t DUCK_H = 8'd16;

	// UART commands
	localparam logic [7:0] CMD_JUMP = "J";
	localparam logic [7:0] CMD_DUCK = "D";

endpackage

/* source/play_state_if.sv */
`timescale 1ns/100ps

interface play_state_if;
	import dino_pkg::*;

	ypos_t dino_y;       // Top of the dino sprite box
	logic ducking;
	xpos_t obstacle_x;   // Left edge of the obstacle
	logic respawn;       // One-cycle request after a clean pass
	logic game_over;

	modport playfield (
		output dino_y, ducking, obstacle_x,
		input respawn, game_over
	);

	modport referee (
		input dino_y, ducking, obstacle_x,
		output respawn, game_over
	);

endinterface

/* source/player_controls.sv */
`timescale 1ns/100ps

module player_controls (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_jump_key,
	input logic i_duck_key,
	input logic i_byte_valid,
	input logic [7:0] i_byte,
	output logic o_jump,
	output logic o_duck
);
	import dino_pkg::*;

	logic [1:0] jump_sync;   // Bit 1 is the synchronized key
	logic [1:0] duck_sync;
	logic cmd_jump;
	logic cmd_duck;

	// Other received bytes fall through here
	assign cmd_jump = i_byte_valid && (i_byte == CMD_JUMP);
	assign cmd_duck = i_byte_valid && (i_byte == CMD_DUCK);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			jump_sync <= 2'b00;
			duck_sync <= 2'b00;
		end else begin
			jump_sync <= {jump_sync[0], i_jump_key};
			duck_sync <= {duck_sync[0], i_duck_key};
		end
	end

	// Key or command, whichever comes
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_jump <= 1'b0;
			o_duck <= 1'b0;
		end else begin
			o_jump <= jump_sync[1] | cmd_jump;
			o_duck <= duck_sync[1] | cmd_duck;
		end
	end

endmodule

/* source/playfield.sv */
`timescale 1ns/100ps

module playfield #(
	parameter int TICK_CYCLES = 524288
) (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_jump,
	input logic i_duck,
	play_state_if.playfield state
);
	import dino_pkg::*;

	localparam int TICK_W = $clog2(TICK_CYCLES + 1);

	logic freeze;
	logic [TICK_W-1:0] tick_cnt;
	logic tick;
	jump_state_e jump_state;
	vel_t velocity;
	ypos_t dino_y;
	logic signed [10:0] next_y;       // Wide enough to see a landing
	logic [DUCK_CNT_W-1:0] duck_cnt;  // Ticks of duck left
	logic ducking;
	xpos_t obstacle_x;
	xpos_t respawn_ofs;
	logic [15:0] lfsr;
	logic lfsr_fb;

	// Crash holds the whole field at its start position
	assign freeze = !i_rst_n || state.game_over;
	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	always_ff @(posedge i_clock) begin
		if (freeze || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign next_y = $signed({3'b000, dino_y}) + {velocity[9], velocity};

	always_ff @(posedge i_clock) begin
		if (freeze) begin
			jump_state <= RUNNING;
			velocity <= '0;
			dino_y <= GROUND_Y;
		end else if (i_jump && jump_state == RUNNING && !ducking) begin
			velocity <= JUMP_FORCE;      // Wins over a tick in the same cycle
			jump_state <= AIRBORNE;
		end else if (tick && jump_state == AIRBORNE) begin
			if (next_y >= $signed({3'b000, GROUND_Y})) begin
				dino_y <= GROUND_Y;
				velocity <= '0;
				jump_state <= RUNNING;
			end else begin
				dino_y <= next_y[7:0];
				velocity <= velocity + GRAVITY;
			end
		end
	end

	// Duck only from the ground
	always_ff @(posedge i_clock) begin
		if (freeze) begin
			duck_cnt <= '0;
		end else if (i_duck && jump_state == RUNNING && !ducking) begin
			duck_cnt <= DUCK_CNT_W'(DUCK_TICKS);
		end else if (tick && ducking) begin
			duck_cnt <= duck_cnt - 1'b1;
		end
	end

	assign ducking = (duck_cnt != '0);

	assign lfsr_fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
	assign respawn_ofs = xpos_t'(lfsr[8:0] % 9'(RESPAWN_SPAN));

	always_ff @(posedge i_clock) begin
		if (freeze) begin
			obstacle_x <= OBS_WRAP_X;
			lfsr <= LFSR_SEED;
		end else if (state.respawn) begin
			obstacle_x <= OBS_WRAP_X + respawn_ofs;   // Off screen by a random gap
			lfsr <= {lfsr[14:0], lfsr_fb};
		end else if (tick) begin
			if (obstacle_x <= 9'd1) begin
				obstacle_x <= OBS_WRAP_X;
			end else begin
				obstacle_x <= obstacle_x - 1'b1;
			end
		end
	end

	assign state.dino_y = dino_y;
	assign state.ducking = ducking;
	assign state.obstacle_x = obstacle_x;

endmodule

/* source/referee.sv */
`timescale 1ns/100ps

module referee (
	input logic i_clock,
	input logic i_rst_n,
	play_state_if.referee state,
	output dino_pkg::score_t o_score,
	output dino_pkg::score_t o_high_score
);
	import dino_pkg::*;

	xpos_t d_left;
	xpos_t d_right;
	ypos_t d_top;
	ypos_t d_bottom;
	xpos_t obs_right;
	ypos_t obs_bottom;
	logic collision;
	logic prev_collision;
	xpos_t prev_x;
	logic pass;
	logic game_over;
	logic respawn;
	score_t score;
	score_t high_score = '0;   // Power-up value only

	// Dino hitbox, lower and shorter while ducking
	assign d_left = DINO_X + DINO_HB_X_OFS;
	assign d_right = d_left + DINO_HB_W;
	assign d_top = state.dino_y + (state.ducking ? DUCK_TOP : STAND_TOP);
	assign d_bottom = d_top + (state.ducking ? DUCK_H : STAND_H);
	assign obs_right = state.obstacle_x + xpos_t'(OBS_SIZE);
	assign obs_bottom = OBS_Y + ypos_t'(OBS_SIZE);

	// Edges touching count as a hit
	assign collision = (d_right >= state.obstacle_x) && (d_left <= obs_right) &&
		(d_bottom >= OBS_Y) && (d_top <= obs_bottom);

	// Obstacle crosses the dino's left edge
	assign pass = (prev_x > DINO_X) && (state.obstacle_x <= DINO_X);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			game_over <= 1'b0;
			prev_collision <= 1'b0;
			prev_x <= OBS_WRAP_X;
			score <= '0;
			respawn <= 1'b0;
		end else begin
			prev_collision <= collision;
			prev_x <= state.obstacle_x;
			respawn <= 1'b0;
			if (collision) begin
				game_over <= 1'b1;
			end
			if (pass && !collision && !prev_collision && !game_over) begin
				score <= score + 1'b1;
				respawn <= 1'b1;
			end
		end
	end

	// Best score is taken as game_over rises
	always_ff @(posedge i_clock) begin
		if (collision && !game_over && score > high_score) begin
			high_score <= score;
		end
	end

	assign state.game_over = game_over;
	assign state.respawn = respawn;
	assign o_score = score;
	assign o_high_score = high_score;

endmodule

/* source/score_display.sv */
`timescale 1ns/100ps

module score_display (
	input dino_pkg::score_t i_score,
	input dino_pkg::score_t i_high_score,
	output dino_pkg::seg_t o_hex0,
	output dino_pkg::seg_t o_hex1,
	output dino_pkg::seg_t o_hex2,
	output dino_pkg::seg_t o_hex3,
	output dino_pkg::seg_t o_hex4,
	output dino_pkg::seg_t o_hex5
);
	import dino_pkg::*;

	// One decimal digit of value at the given place, common anode
	function automatic seg_t digit_seg(input score_t value, input score_t place);
		logic [3:0] digit;
		digit = 4'((value / place) % 16'd10);
		case (digit)
			4'd0: digit_seg = 7'b1000000;
			4'd1: digit_seg = 7'b1111001;
			4'd2: digit_seg = 7'b0100100;
			4'd3: digit_seg = 7'b0110000;
			4'd4: digit_seg = 7'b0011001;
			4'd5: digit_seg = 7'b0010010;
			4'd6: digit_seg = 7'b0000010;
			4'd7: digit_seg = 7'b1111000;
			4'd8: digit_seg = 7'b0000000;
			4'd9: digit_seg = 7'b0010000;
			default: digit_seg = 7'b1111111;   // Blank
		endcase
	endfunction

	// Thousands and up are not shown
	assign o_hex0 = digit_seg(i_score, 16'd1);
	assign o_hex1 = digit_seg(i_score, 16'd10);
	assign o_hex2 = digit_seg(i_score, 16'd100);
	assign o_hex3 = digit_seg(i_high_score, 16'd1);
	assign o_hex4 = digit_seg(i_high_score, 16'd10);
	assign o_hex5 = digit_seg(i_high_score, 16'd100);

endmodule

/* source/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
	parameter int BAUD_DIV = 27
) (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_rx,
	output logic o_byte_valid,
	output logic [7:0] o_byte
);
	import dino_pkg::*;

	localparam int DIV_W = $clog2(BAUD_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic os_tick;
	logic rx_meta;
	logic rx_sync;
	rx_state_e rx_state;
	logic [3:0] os_cnt;     // Oversampling ticks left in the current bit
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;

	// 16x oversampling tick
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (div_cnt == DIV_W'(BAUD_DIV - 1)) begin
			div_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	// Line idles high
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			rx_state <= RX_IDLE;
			os_cnt <= 4'd0;
			bit_idx <= 3'd0;
			o_byte_valid <= 1'b0;
		end else begin
			o_byte_valid <= 1'b0;
			if (os_tick) begin
				case (rx_state)
					RX_IDLE: begin
						if (!rx_sync) begin
							rx_state <= RX_START;
							os_cnt <= 4'd7;        // Half a bit to the start bit centre
						end
					end
					RX_START: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else if (!rx_sync) begin
							rx_state <= RX_DATA;
							os_cnt <= 4'd15;
							bit_idx <= 3'd0;
						end else begin
							rx_state <= RX_IDLE;   // Glitch, not a start bit
						end
					end
					RX_DATA: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else begin
							shift_reg <= {rx_sync, shift_reg[7:1]};   // LSB first
							os_cnt <= 4'd15;
							if (bit_idx == 3'd7) begin
								rx_state <= RX_STOP;
							end
							bit_idx <= bit_idx + 1'b1;
						end
					end
					RX_STOP: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else begin
							rx_state <= RX_IDLE;
							if (rx_sync) begin
								o_byte <= shift_reg;
								o_byte_valid <= 1'b1;
							end
						end
					end
					default: rx_state <= RX_IDLE;
				endcase
			end
		end
	end

endmodule

/* verilog.f */
source/dino_pkg.sv
source/play_state_if.sv
source/uart_rx.sv
source/player_controls.sv
source/playfield.sv
source/referee.sv
source/score_display.sv
source/dino_game.sv
sim/tb_clock.sv
sim/dino_game_tb.sv
